// ==== Makefile ====
TOOL    = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = tbFpConv
FLIST   = sources.f
LOG     = sim.log
PASSMSG = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== sources.f ====
src/fpConvPkg.sv
src/fpConvApb.sv
src/convCtrl.sv
src/expCounter.sv
src/fpNormalize.sv
src/fpRound.sv
src/fpConvTop.sv
tb/fpConv_checker.sv
tb/tbFpConv.sv

// ==== src/convCtrl.sv ====
`default_nettype none

module convCtrl import fpConvPkg::*; (
	input  wire  clk,
	input  wire  rstN,
	input  wire  start,      // accepted only while not busy
	input  wire  msbSet,     // magnitude will be normalized after this cycle
	input  wire  exhausted,  // last allowed shift is happening
	output logic loadEn,
	output logic cntLoad,
	output logic shiftEn,
	output logic resultEn,
	output logic busy,
	output logic done
);

	convState_e state;
	convState_e nextState;

	// ==================================================
	// state register
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rstN)
			state <= stIdle;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			stIdle:  if (start) nextState = stLoad;
			stLoad:  nextState = msbSet ? stRound : stNorm;  // already normalized skips norm
			stNorm:  if (msbSet || exhausted) nextState = stRound;
			stRound: nextState = stDone;
			stDone:  nextState = start ? stLoad : stIdle;
			default: nextState = stIdle;
		endcase
	end

	// strobes straight from state
	assign loadEn   = (state == stLoad);
	assign cntLoad  = (state == stLoad);
	assign shiftEn  = (state == stNorm);   // norm is only entered with msb clear
	assign resultEn = (state == stRound);
	assign busy     = (state == stLoad) || (state == stNorm) || (state == stRound);

	// done is sticky until software starts the next conversion
	always_ff @(posedge clk) begin
		if (!rstN)
			done <= 1'b0;
		else if (start)
			done <= 1'b0;
		else if (state == stRound)
			done <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== src/expCounter.sv ====
`default_nettype none

module expCounter import fpConvPkg::*; #(
	parameter int intWid = 32
) (
	input  wire    clk,
	input  wire    rstN,
	input  wire    cntLoad,
	input  wire    shiftEn,
	output fpExp_t expOut,
	output logic   exhausted
);

	localparam int tallyW = $clog2(intWid);

	// exponent of an integer whose top bit is set
	localparam fpExp_t expStart = fpExp_t'(expBias + intWid - 1);

	logic [tallyW-1:0] tally;   // shifts done so far

	always_ff @(posedge clk) begin
		if (!rstN) begin
			expOut <= '0;
			tally  <= '0;
		end else if (cntLoad) begin
			expOut <= expStart;
			tally  <= '0;
		end else if (shiftEn) begin
			expOut <= expOut - 1'b1;   // each left shift halves the weight
			tally  <= tally + 1'b1;
		end
	end

	// tally hits intWid-1 with the shift in progress
	// caps the loop for a zero operand
	assign exhausted = shiftEn & (tally == tallyW'(intWid - 2));

endmodule

`default_nettype wire

// ==== src/fpConvApb.sv ====
`default_nettype none

module fpConvApb import fpConvPkg::*; #(
	parameter int intWid = 32
) (
	input  wire        clk,
	input  wire        rstN,
	// apb slave side
	input  wire        psel,
	input  wire        penable,
	input  wire        pwrite,
	input  wire apbAddr_t paddr,
	input  wire apbData_t pwdata,
	output apbData_t   prdata,
	output logic       pready,
	output logic       pslverr,
	// converter side
	input  wire        busy,
	input  wire        done,
	input  wire floatWord_t result,
	output logic       start,
	output rndMode_e   rndMode,
	output logic [intWid-1:0] operand
);

	logic access;        // second phase of a transfer
	logic wrAccess;
	logic rdAccess;
	logic mapped;
	logic busyReject;    // operand or ctrl write while converting
	logic wrCtrl;
	logic wrOperand;

	// ==================================================
	// access decode
	// ==================================================
	assign access   = psel & penable;
	assign wrAccess = access & pwrite;
	assign rdAccess = access & ~pwrite;

	always_comb begin
		case (paddr)
			regCtrl, regStatus, regOperand, regResult: mapped = 1'b1;
			default:                                   mapped = 1'b0;
		endcase
	end

	assign busyReject = wrAccess & busy & (paddr == regCtrl || paddr == regOperand);
	assign wrCtrl     = wrAccess & ~busy & (paddr == regCtrl);
	assign wrOperand  = wrAccess & ~busy & (paddr == regOperand);

	assign pready  = access;                        // no wait states ever
	assign pslverr = access & (~mapped | busyReject);

	// start is a single-cycle strobe in the access phase
	assign start = wrCtrl & pwdata[0];

	// ==================================================
	// write side
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			operand <= '0;
			rndMode <= rmNearEven;
		end else begin
			if (wrOperand)
				operand <= pwdata[intWid-1:0];
			if (wrCtrl)
				rndMode <= rndMode_e'(pwdata[3:1]);  // reserved codes kept as written
		end
	end

	// ==================================================
	// read mux
	// ==================================================
	always_comb begin
		prdata = '0;
		if (rdAccess) begin
			case (paddr)
				regCtrl:    prdata = {28'd0, rndMode, 1'b0};  // start always reads 0
				regStatus:  prdata = {30'd0, done, busy};
				regOperand: prdata = apbData_t'(operand);     // zero padded above intWid
				regResult:  prdata = result;
				default:    prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/fpConvPkg.sv ====
`default_nettype none

package fpConvPkg;

	// ==================================================
	// binary32 layout
	// ==================================================
	localparam int expBits = 8;
	localparam int manBits = 23;     // stored fraction bits, hidden bit excluded
	localparam int expBias = 127;

	typedef logic [3:0]               apbAddr_t;    // register byte address
	typedef logic [31:0]              apbData_t;
	typedef logic [expBits+manBits:0] floatWord_t;  // sign, exponent, fraction
	typedef logic [expBits-1:0]       fpExp_t;      // biased exponent

	typedef enum logic [2:0] {
		rmNearEven = 3'd0,
		rmToZero   = 3'd1,
		rmToPosInf = 3'd2,
		rmToNegInf = 3'd3    // codes 4..7 reserved and truncate
	} rndMode_e;

	typedef enum logic [2:0] {
		stIdle,
		stLoad,
		stNorm,
		stRound,
		stDone
	} convState_e;

	// intermediate format handed from normalizer to rounder
	typedef struct packed {
		logic             sign;
		fpExp_t           exponent;
		logic [manBits:0] mantissa;  // leading one kept explicit
		logic             roundBit;
		logic             sticky;    // or of everything below roundBit
	} fpInter_t;

	// ==================================================
	// register map
	// ==================================================
	localparam apbAddr_t regCtrl    = 4'h0;  // start, rounding mode
	localparam apbAddr_t regStatus  = 4'h4;  // busy, done
	localparam apbAddr_t regOperand = 4'h8;
	localparam apbAddr_t regResult  = 4'hC;

endpackage

`default_nettype wire

// ==== src/fpConvTop.sv ====
`default_nettype none

module fpConvTop import fpConvPkg::*; #(
	parameter int intWid = 32
) (
	input  wire        clk,
	input  wire        rstN,
	input  wire        psel,
	input  wire        penable,
	input  wire        pwrite,
	input  wire apbAddr_t paddr,
	input  wire apbData_t pwdata,
	output apbData_t   prdata,
	output logic       pready,
	output logic       pslverr,
	output logic       irq        // done flag
);

	// ==================================================
	// internal nets
	// ==================================================
	logic              start;
	rndMode_e          rndMode;
	logic [intWid-1:0] operand;
	logic              loadEn;
	logic              cntLoad;
	logic              shiftEn;
	logic              resultEn;
	logic              busy;
	logic              msbSet;
	logic              exhausted;
	fpExp_t            expOut;
	fpInter_t          inter;
	floatWord_t        result;

	fpConvApb #(.intWid(intWid)) fpConvApb_i (
		.clk, .rstN,
		.psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.busy, .done(irq), .result,
		.start, .rndMode, .operand
	);

	convCtrl convCtrl_i (
		.clk, .rstN,
		.start, .msbSet, .exhausted,
		.loadEn, .cntLoad, .shiftEn, .resultEn,
		.busy, .done(irq)   // done doubles as the interrupt
	);

	expCounter #(.intWid(intWid)) expCounter_i (
		.clk, .rstN,
		.cntLoad, .shiftEn,
		.expOut, .exhausted
	);

	fpNormalize #(.intWid(intWid)) fpNormalize_i (
		.clk, .rstN,
		.loadEn, .shiftEn, .operand, .expOut,
		.msbSet, .inter
	);

	fpRound fpRound_i (
		.clk, .rstN,
		.resultEn, .rndMode, .inter,
		.result
	);

endmodule

`default_nettype wire

// ==== src/fpNormalize.sv ====
`default_nettype none

module fpNormalize import fpConvPkg::*; #(
	parameter int intWid = 32
) (
	input  wire              clk,
	input  wire              rstN,
	input  wire              loadEn,
	input  wire              shiftEn,
	input  wire [intWid-1:0] operand,   // two's complement
	input  wire fpExp_t      expOut,
	output logic             msbSet,
	output fpInter_t         inter
);

	// magnitude padded below so mantissa, round and sticky always exist
	localparam int alignW = intWid + manBits + 3;

	logic              sign;
	logic [intWid-1:0] mag;       // unsigned magnitude, shifted left in place
	logic [intWid-1:0] absVal;
	logic [alignW-1:0] aligned;

	// most negative value comes out as 2^(intWid-1) unsigned
	assign absVal = operand[intWid-1] ? (~operand + 1'b1) : operand;

	// ==================================================
	// magnitude register
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			sign <= 1'b0;
			mag  <= '0;
		end else if (loadEn) begin
			sign <= operand[intWid-1];
			mag  <= absVal;
		end else if (shiftEn) begin
			mag <= {mag[intWid-2:0], 1'b0};
		end
	end

	// top bit as it will stand after this cycle
	// lets the controller leave load or norm without an extra cycle
	always_comb begin
		if (loadEn)
			msbSet = absVal[intWid-1];
		else if (shiftEn)
			msbSet = mag[intWid-2];
		else
			msbSet = mag[intWid-1];
	end

	// ==================================================
	// intermediate format
	// ==================================================
	assign aligned = {mag, {(manBits + 3){1'b0}}};

	always_comb begin
		inter.sign     = sign;
		inter.exponent = (mag == '0) ? '0 : expOut;   // zero has a zero exponent field
		inter.mantissa = aligned[alignW-1 -: manBits+1];
		inter.roundBit = aligned[alignW-manBits-2];
		inter.sticky   = |aligned[alignW-manBits-3:0];
	end

endmodule

`default_nettype wire

// ==== src/fpRound.sv ====
`default_nettype none

module fpRound import fpConvPkg::*; (
	input  wire        clk,
	input  wire        rstN,
	input  wire        resultEn,
	input  wire rndMode_e rndMode,
	input  wire fpInter_t inter,
	output floatWord_t result
);

	logic                       rndUp;      // add one ulp
	logic                       inexact;
	logic [expBits+manBits-1:0] sum;        // exponent and fraction after rounding
	fpExp_t                     expRnd;
	logic [manBits-1:0]         fracRnd;
	logic                       isInf;
	floatWord_t                 packedWord;

	assign inexact = inter.roundBit | inter.sticky;

	// ==================================================
	// round-up decision
	// ==================================================
	always_comb begin
		case (rndMode)
			rmNearEven: rndUp = inter.roundBit & (inter.mantissa[0] | inter.sticky);
			rmToPosInf: rndUp = inexact & ~inter.sign;
			rmToNegInf: rndUp = inexact & inter.sign;
			default:    rndUp = 1'b0;    // toward zero and the reserved codes
		endcase
	end

	// hidden bit dropped before the add
	// a fraction overflow ripples straight into the exponent
	assign sum = {inter.exponent, inter.mantissa[manBits-1:0]}
		+ (expBits + manBits)'(rndUp);

	assign expRnd  = sum[expBits+manBits-1:manBits];
	assign fracRnd = sum[manBits-1:0];

	// all-ones exponent means infinity
	// needs intWid near 128 so never hit at 32 bits
	assign isInf = &expRnd;

	assign packedWord = {inter.sign, expRnd, isInf ? {manBits{1'b0}} : fracRnd};

	// ==================================================
	// result register
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rstN)
			result <= '0;
		else if (resultEn)
			result <= packedWord;   // held until the next round state
	end

endmodule

`default_nettype wire

// ==== tb/fpConv_checker.sv ====
`default_nettype none

module fpConvChecker #(
	parameter int intWid = 32
) (
	input wire clk,
	input wire rstN,
	input wire access,   // psel and penable both high
	input wire pready,
	input wire busy,
	input wire done,
	input wire start,
	input wire idle      // block is at rest
);
	timeunit 1ns;
	timeprecision 1ps;

	int runLen;   // cycles spent away from idle

	always_ff @(posedge clk) begin
		if (!rstN || idle)
			runLen <= 0;
		else
			runLen <= runLen + 1;
	end

	readyInAccess: assert property (@(posedge clk) disable iff (!rstN) access |-> pready)
		else $error("pready low in an APB access phase");
	busyNotDone: assert property (@(posedge clk) disable iff (!rstN) !(busy && done))
		else $error("busy and done high together");
	startAtRest: assert property (@(posedge clk) disable iff (!rstN) start |-> (idle || done))
		else $error("start accepted while a conversion runs");
	backToIdle: assert property (@(posedge clk) disable iff (!rstN) runLen <= intWid + 4)
		else $error("conversion did not return to idle in time");

endmodule

// bus side, rest means not busy
bind fpConvApb fpConvChecker #(.intWid(intWid)) apbChk_i (.clk, .rstN,
	.access(psel & penable), .pready, .busy, .done, .start, .idle(!busy));

// controller has no bus, so access is tied off
bind convCtrl fpConvChecker ctrlChk_i (.clk, .rstN, .access(1'b0), .pready(1'b1),
	.busy, .done, .start, .idle(state == stIdle));

`default_nettype wire

// ==== tb/tbFpConv.sv ====
`default_nettype none

module tbFpConv import fpConvPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int intWid    = 32;
	localparam int pollLimit = 200;

	typedef struct packed {
		logic [31:0] operand;
		logic [2:0]  mode;
		floatWord_t  got;
	} convRec_t;

	logic     clk;
	logic     rstN;
	logic     psel;
	logic     penable;
	logic     pwrite;
	apbAddr_t paddr;
	apbData_t pwdata;
	apbData_t prdata;
	logic     pready;
	logic     pslverr;
	logic     irq;
	integer   seed;
	convRec_t pending[$];   // results waiting for the compare process

	fpConvTop #(.intWid(intWid)) fpConvTop_i (.clk, .rstN, .psel, .penable, .pwrite,
		.paddr, .pwdata, .prdata, .pready, .pslverr, .irq);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abortRun(input string line);
		$display("%s", line);
		$display("Something failed");
		$fatal(1);
	endtask

	// ==================================================
	// reference model, straight from the binary32 rules
	// ==================================================
	function automatic floatWord_t refConvert(input logic [31:0] op, input logic [2:0] mode);
		logic        sign;
		logic [31:0] mag;
		logic [31:0] norm;
		logic [24:0] mant;   // spare top bit catches the rounding carry
		logic [7:0]  expo;
		logic        up;
		int          lead;
		sign = op[31];
		mag  = sign ? (32'd0 - op) : op;   // 0x80000000 stays as 2^31
		if (mag == 32'd0)
			return 32'd0;
		lead = 31;
		while (!mag[lead])
			lead--;
		norm = mag << (31 - lead);   // leading one on bit 31
		expo = 8'(127 + lead);
		mant = {1'b0, norm[31:8]};
		case (mode)
			3'd0:    up = norm[7] & (mant[0] | (|norm[6:0]));
			3'd2:    up = (|norm[7:0]) & ~sign;
			3'd3:    up = (|norm[7:0]) & sign;
			default: up = 1'b0;    // toward zero, reserved codes too
		endcase
		mant = mant + 25'(up);
		if (mant[24]) begin   // 1.11..1 rolled over to 10.00..0
			expo = expo + 8'd1;
			mant = mant >> 1;
		end
		return {sign, expo, mant[22:0]};
	endfunction

	// ==================================================
	// APB transfers
	// ==================================================
	task automatic apbXfer(input apbAddr_t addr, input logic write, input apbData_t wdata,
			input logic expErr, output apbData_t rdata);
		@(posedge clk);
		#2;
		psel    = 1'b1;   // setup phase
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#2;
		penable = 1'b1;   // access phase
		#5;
		rdata = prdata;
		assert (pready === 1'b1) else abortRun("pready was low in an APB access cycle");
		assert (pslverr === expErr) else abortRun($sformatf(
			"[FAIL] %0t pslverr %b at addr %h, expected %b", $time, pslverr, addr, expErr));
		if (!write && addr == regStatus) begin
			assert (irq === prdata[1]) else abortRun($sformatf(
				"[FAIL] %0t irq %b but status done %b", $time, irq, prdata[1]));
		end
		@(posedge clk);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apbWrite(input apbAddr_t addr, input apbData_t data, input logic expErr);
		apbData_t unused;
		apbXfer(addr, 1'b1, data, expErr, unused);
	endtask

	task automatic apbRead(input apbAddr_t addr, output apbData_t data, input logic expErr);
		apbXfer(addr, 1'b0, 32'd0, expErr, data);
	endtask

	// poll status until done, bounded in clocks
	task automatic waitDone();
		apbData_t st;
		int       cycles;
		logic     seen;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < pollLimit) begin
			apbRead(regStatus, st, 1'b0);
			assert (st[1:0] !== 2'b11) else abortRun("status showed busy and done together");
			seen   = st[1];
			cycles += 3;   // one status read spans three clocks
		end
		if (!seen)
			abortRun("timeout: conversion never reported done within the polling limit");
	endtask

	task automatic convertOne(input logic [31:0] op, input logic [2:0] mode);
		apbData_t res;
		apbWrite(regOperand, op, 1'b0);
		apbWrite(regCtrl, {28'd0, mode, 1'b1}, 1'b0);
		waitDone();
		apbRead(regResult, res, 1'b0);
		pending.push_back({op, mode, res});
	endtask

	// compare process
	always @(posedge clk) begin : compareBlk
		convRec_t   rec;
		floatWord_t want;
		if (pending.size() != 0) begin
			rec  = pending.pop_front();
			want = refConvert(rec.operand, rec.mode);
			assert (rec.got === want) else abortRun($sformatf(
				"[FAIL] %0t op=%h mode=%0d expected=%h got=%h",
				$time, rec.operand, rec.mode, want, rec.got));
		end
	end

	// ==================================================
	// stimulus
	// ==================================================
	initial begin : stimulus
		apbData_t    rd;
		int          m;
		int          drain;
		logic [31:0] exactOps[5];
		logic [31:0] roundOps[6];
		rstN     = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		seed     = 32'hf6f0196f;
		exactOps = '{32'd0, 32'd1, 32'hFFFF_FFFF, 32'h0100_0000, 32'h8000_0000};
		roundOps = '{32'd16777217, 32'd16777219, 32'h7FFF_FFFF,
			32'hFEFF_FFFF, 32'hFEFF_FFFD, 32'h8000_0001};   // includes negatives
		repeat (8) @(posedge clk);
		#2;
		rstN = 1'b1;

		foreach (exactOps[k])
			for (m = 0; m < 4; m++)
				convertOne(exactOps[k], 3'(m));
		foreach (roundOps[k])
			for (m = 0; m < 4; m++)
				convertOne(roundOps[k], 3'(m));

		// reserved codes read back as written and truncate
		for (m = 4; m < 8; m++) begin
			apbWrite(regCtrl, {28'd0, 3'(m), 1'b0}, 1'b0);
			apbRead(regCtrl, rd, 1'b0);
			assert (rd === {28'd0, 3'(m), 1'b0}) else abortRun($sformatf(
				"[FAIL] %0t ctrl read %h after writing mode %0d", $time, rd, m));
			convertOne(32'h7FFF_FFFF, 3'(m));
			convertOne(32'hFEFF_FFFD, 3'(m));
		end

		// zero operand gives the longest run, room for busy checks
		apbWrite(regOperand, 32'd0, 1'b0);
		apbWrite(regCtrl, 32'd1, 1'b0);
		apbRead(regStatus, rd, 1'b0);
		assert (rd[1:0] === 2'b01) else abortRun($sformatf(
			"[FAIL] %0t status %b after start, expected busy only", $time, rd[1:0]));
		apbWrite(regOperand, 32'h1234_5678, 1'b1);   // rejected while busy
		apbWrite(regCtrl, {28'd0, 3'd2, 1'b1}, 1'b1);
		waitDone();
		apbRead(regOperand, rd, 1'b0);
		assert (rd === 32'd0) else abortRun($sformatf(
			"[FAIL] %0t operand %h changed by a write while busy", $time, rd));
		apbRead(regResult, rd, 1'b0);
		pending.push_back({32'd0, 3'd0, rd});
		apbRead(4'h2, rd, 1'b1);                     // unmapped
		apbWrite(4'h6, 32'hFFFF_FFFF, 1'b1);

		repeat (300)
			convertOne($random(seed), 3'($random(seed)));

		drain = 0;
		while (pending.size() != 0 && drain < 10) begin
			@(posedge clk);
			drain++;
		end
		if (pending.size() == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			abortRun("timeout: compare process left results unchecked");
		end
	end

endmodule

`default_nettype wire
